/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and address width
`define XLEN        32

// Architectural register file
`define REG_COUNT   32
`define REG_AW      5

// Instruction memory depth in words
`define IMEM_WORDS  512
`define IMEM_AW     9

// Data memory depth in words
`define DMEM_WORDS  64
`define DMEM_AW     6

`define RESET_PC    32'h0000_0000

`endif

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011, // Register-register arithmetic
        OP_IMM = 7'b0010011, // Register-immediate arithmetic
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101, // srl / sra
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam logic [2:0] F3_WORD  = 3'b010;     // lw / sw width
    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_ALT   = 7'b0100000; // sub, sra, srai

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;    // Shift forms carry funct7 in 11:5
        logic [4:0]  rs1;
        funct3_e     funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    // One fetched word viewed by format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } insn_u;

endpackage

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

`include "rv_consts.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        alu_op_e            alu_op;
        logic               use_imm; // Operand b from imm
        logic               reg_we;
        logic               mem_re;
        logic               mem_we;
        logic               illegal;
        logic [`XLEN-1:0]   imm;     // Sign-extended
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        logic               illegal;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   insn;
        logic               rd_we;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   rd_data;
        logic               mem_we;
        logic [`XLEN-1:0]   mem_addr;
        logic [`XLEN-1:0]   mem_wdata;
    } retire_t;

endpackage

`default_nettype wire

/* inst_mem.sv */
`default_nettype none

`include "rv_consts.svh"

module inst_mem (
    input  wire logic                CLK,
    input  wire logic                we,
    input  wire logic [`IMEM_AW-1:0] waddr,
    input  wire logic [`XLEN-1:0]    wdata,
    input  wire logic [`XLEN-1:0]    pc,
    output rv_isa_pkg::insn_u        insn
);

    import rv_isa_pkg::*;

    logic [`XLEN-1:0]    mem [`IMEM_WORDS];
    logic [`IMEM_AW-1:0] fetch_idx;

    assign fetch_idx = pc[`IMEM_AW+1:2]; // Drop byte offset and wrap to depth

    // Program load port
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_comb begin
        insn = insn_u'(mem[fetch_idx]);
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

`include "rv_consts.svh"

module reg_file (
    input  wire logic               CLK,
    input  wire logic               RST,
    input  wire logic [`REG_AW-1:0] rs1,
    input  wire logic [`REG_AW-1:0] rs2,
    input  wire logic [`REG_AW-1:0] rd,
    input  wire logic [`XLEN-1:0]   rd_data,
    input  wire logic               we,
    output logic      [`XLEN-1:0]   rs1_data,
    output logic      [`XLEN-1:0]   rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 stays zero
            regs[rd] <= rd_data;
        end
    end

    // Old value seen during a same-cycle write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* data_mem.sv */
`default_nettype none

`include "rv_consts.svh"

module data_mem (
    input  wire logic             CLK,
    input  wire logic [`XLEN-1:0] addr,
    input  wire logic             we,
    input  wire logic [`XLEN-1:0] wdata,
    output logic      [`XLEN-1:0] rdata
);

    logic [`XLEN-1:0]    mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] idx;

    // Word index with the byte offset ignored
    assign idx = addr[`DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];   // Combinational read for lw

endmodule

`default_nettype wire

/* decoder.sv */
`default_nettype none

`include "rv_consts.svh"

module decoder (
    input  wire rv_isa_pkg::insn_u insn,
    output core_pkg::ctrl_t        ctrl
);

    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [6:0]       shift_f7;  // funct7 of slli / srli / srai
    logic             sr_imm_alt;
    logic             r_legal;
    logic             i_legal;

    // funct3 plus the alternate bit picks the operation
    function automatic alu_op_e alu_map(input funct3_e f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign i_imm = {{(`XLEN-12){insn.i.imm[11]}}, insn.i.imm};
    assign s_imm = {{(`XLEN-12){insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};

    assign shift_f7   = insn.i.imm[11:5];
    assign sr_imm_alt = (insn.i.funct3 == F3_SR) && insn.i.imm[10];

    // Only sub and sra may use the alternate funct7
    assign r_legal = (insn.r.funct7 == F7_BASE) ||
                     ((insn.r.funct7 == F7_ALT) &&
                      ((insn.r.funct3 == F3_ADD_SUB) || (insn.r.funct3 == F3_SR)));

    always_comb begin
        case (insn.i.funct3)
            F3_SLL:  i_legal = (shift_f7 == F7_BASE);
            F3_SR:   i_legal = (shift_f7 == F7_BASE) || (shift_f7 == F7_ALT);
            default: i_legal = 1'b1;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD; // Address add for lw / sw
        case (insn.r.opcode)
            OP: begin
                ctrl.alu_op  = alu_map(insn.r.funct3, insn.r.funct7[5]);
                ctrl.reg_we  = 1'b1;
                ctrl.illegal = !r_legal;
            end
            OP_IMM: begin
                ctrl.alu_op  = alu_map(insn.i.funct3, sr_imm_alt);
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.imm     = i_imm;
                ctrl.illegal = !i_legal;
            end
            LOAD: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.mem_re  = 1'b1;
                ctrl.imm     = i_imm;
                ctrl.illegal = (insn.i.funct3 != F3_WORD); // Word loads only
            end
            STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
                ctrl.imm     = s_imm;
                ctrl.illegal = (insn.s.funct3 != F3_WORD);
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // Illegal words retire as no-ops
        if (ctrl.illegal) begin
            ctrl.reg_we = 1'b0;
            ctrl.mem_re = 1'b0;
            ctrl.mem_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

`include "rv_consts.svh"

module alu (
    input  wire core_pkg::alu_op_e      op,
    input  wire logic [`XLEN-1:0]       a,
    input  wire logic [`XLEN-1:0]       b,
    output logic      [`XLEN-1:0]       result
);

    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt); // Sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* single_cpu.sv */
`default_nettype none

`include "rv_consts.svh"

module single_cpu (
    input  wire logic                CLK,
    input  wire logic                RST,
    input  wire logic                load_en,
    input  wire logic [`IMEM_AW-1:0] load_addr,
    input  wire logic [`XLEN-1:0]    load_data,
    output core_pkg::retire_t        retire
);

    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [`XLEN-1:0] pc;
    insn_u            insn;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] mem_rdata;
    logic [`XLEN-1:0] wb_data;
    logic             run;     // Core executing this cycle
    logic             rd_we;
    logic             mem_we;

    assign run = !RST && !load_en;

    // PC parks at reset value while loading
    always_ff @(posedge CLK) begin
        if (RST || load_en) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc + `XLEN'd4;
        end
    end

    inst_mem inst_mem_inst (
        .CLK   (CLK),
        .we    (load_en),
        .waddr (load_addr),
        .wdata (load_data),
        .pc    (pc),
        .insn  (insn)
    );

    reg_file reg_file_inst (
        .CLK      (CLK),
        .RST      (RST),
        .rs1      (insn.r.rs1),
        .rs2      (insn.r.rs2),
        .rd       (insn.r.rd),
        .rd_data  (wb_data),
        .we       (rd_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decoder decoder_inst (
        .insn (insn),
        .ctrl (ctrl)
    );

    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    alu alu_inst (
        .op     (ctrl.alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_res)       // Also the lw / sw address
    );

    data_mem data_mem_inst (
        .CLK   (CLK),
        .addr  (alu_res),
        .we    (mem_we),
        .wdata (rs2_data),
        .rdata (mem_rdata)
    );

    assign rd_we   = run && ctrl.reg_we;
    assign mem_we  = run && ctrl.mem_we;
    assign wb_data = ctrl.mem_re ? mem_rdata : alu_res;

    // One record per cycle for the instruction in flight
    always_comb begin
        retire.valid     = run;
        retire.illegal   = ctrl.illegal;
        retire.pc        = pc;
        retire.insn      = insn;
        retire.rd_we     = rd_we;
        retire.rd        = insn.r.rd;
        retire.rd_data   = wb_data;
        retire.mem_we    = mem_we;
        retire.mem_addr  = alu_res;
        retire.mem_wdata = rs2_data;
    end

endmodule

`default_nettype wire

/* tb_single_cpu.sv */
`default_nettype none

`include "rv_consts.svh"

module tb_single_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int unsigned CLK_PERIOD  = 20;
    localparam int unsigned RST_CYCLES  = 16;
    localparam int unsigned PROG_WORDS  = `IMEM_WORDS;
    localparam int unsigned WATCHDOG_NS = 2 * (RST_CYCLES + 2 * PROG_WORDS + 2) * CLK_PERIOD;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111; // Not implemented here

    logic                CLK;
    logic                RST;
    logic                load_en;
    logic [`IMEM_AW-1:0] load_addr;
    logic [`XLEN-1:0]    load_data;
    retire_t             retire;

    logic [`XLEN-1:0] prog [PROG_WORDS];
    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [`XLEN-1:0] model_dmem [`DMEM_WORDS];
    logic [`XLEN-1:0] exp_pc;
    logic [`XLEN-1:0] exp_rd_data;
    logic [`XLEN-1:0] exp_mem_addr;
    logic [`XLEN-1:0] exp_mem_wdata;
    logic             exp_illegal;
    logic             exp_rd_we;
    logic             exp_mem_we;
    logic             running;      // Program loaded and core executing
    int unsigned      retired;
    int unsigned      check_count;
    int unsigned      mismatch_count;

    single_cpu single_cpu_inst (
        .CLK       (CLK),
        .RST       (RST),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .retire    (retire)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    // RV32I arithmetic by funct3 with alt taken from instruction bit 30
    function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act == exp) else begin
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
            mismatch_count++;
        end
    endtask

    // Reference model for one word against the current model state
    task automatic predict(input logic [31:0] w);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic        legal;
        f3            = w[14:12];
        f7            = w[31:25];
        a             = model_regs[w[19:15]];
        b             = model_regs[w[24:20]];
        imm_i         = {{20{w[31]}}, w[31:20]};
        legal         = 1'b0;
        exp_rd_data   = '0;
        exp_mem_addr  = '0;
        exp_mem_wdata = '0;
        case (w[6:0])
            OPC_OP: begin
                legal       = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
                exp_rd_data = arith(f3, f7[5], a, b);
            end
            OPC_IMM: begin
                legal       = (f3 == 3'd1) ? (f7 == 7'h00) :
                              (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                exp_rd_data = arith(f3, (f3 == 3'd5) && f7[5], a, imm_i);
            end
            OPC_LOAD: begin
                legal       = (f3 == 3'b010);
                addr        = a + imm_i;
                exp_rd_data = model_dmem[addr[`DMEM_AW+1:2]];
            end
            OPC_STORE: begin
                legal         = (f3 == 3'b010);
                exp_mem_addr  = a + {{20{w[31]}}, w[31:25], w[11:7]};
                exp_mem_wdata = b;
            end
            default: legal = 1'b0;
        endcase
        exp_illegal = !legal;
        exp_rd_we   = legal && (w[6:0] != OPC_STORE);
        exp_mem_we  = legal && (w[6:0] == OPC_STORE);
    endtask

    task automatic build_program();
        int unsigned idx;
        int unsigned cls;
        logic [2:0]  f3;
        logic [2:0]  bad_f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        idx = 0;
        for (int r = 1; r < `REG_COUNT; r++) begin   // Random register contents
            prog[idx] = enc_i(12'($urandom_range(4095)), 5'd0, 3'd0, 5'(r), OPC_IMM);
            idx++;
        end
        for (int d = 0; d < `DMEM_WORDS; d++) begin  // Every data word written once
            prog[idx] = enc_sw(12'(d * 4), 5'($urandom_range(1, 31)), 5'd0);
            idx++;
        end
        while (idx < PROG_WORDS) begin
            rd     = 5'($urandom_range(31));
            rs1    = 5'($urandom_range(31));
            rs2    = 5'($urandom_range(31));
            f3     = 3'($urandom_range(7));
            bad_f3 = (f3 == 3'b010) ? 3'b000 : f3; // Byte or halfword width
            imm    = 12'($urandom_range(4095));
            alt    = ($urandom_range(1) == 1) && (f3 == 3'd0 || f3 == 3'd5);
            cls    = $urandom_range(99);
            if (cls < 3) begin
                case ($urandom_range(4))
                    0: prog[idx] = enc_r(7'h01, rs2, rs1, f3, rd, OPC_OP); // Multiply group
                    1: prog[idx] = enc_i({7'h20, imm[4:0]}, rs1, 3'd1, rd, OPC_IMM); // Bad slli
                    2: prog[idx] = enc_i(imm, rs1, bad_f3, rd, OPC_LOAD);
                    3: prog[idx] = enc_r(imm[11:5], rs2, rs1, bad_f3, imm[4:0], OPC_STORE);
                    default: prog[idx] = enc_i(imm, rs1, f3, rd, OPC_JAL);
                endcase
            end else if (cls < 43) begin
                prog[idx] = enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP);
            end else if (cls < 73) begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {((f3 == 3'd5) && alt) ? 7'h20 : 7'h00, imm[4:0]};
                prog[idx] = enc_i(imm, rs1, f3, rd, OPC_IMM);
            end else if (cls < 87) begin
                prog[idx] = enc_i(imm, rs1, 3'b010, rd, OPC_LOAD);
            end else begin
                prog[idx] = enc_sw(imm, rs2, rs1);
            end
            idx++;
        end
    endtask

    always @(posedge CLK) begin : retire_check
        logic [31:0] word;
        if (!running) begin
            check_field("retire.valid", 32'd0, retire.valid);
            check_field("retire.rd_we", 32'd0, retire.rd_we);
            check_field("retire.mem_we", 32'd0, retire.mem_we);
        end else if (retired < PROG_WORDS) begin
            word = prog[exp_pc[`IMEM_AW+1:2]];
            predict(word);
            check_field("retire.valid", 32'd1, retire.valid);
            check_field("retire.pc", exp_pc, retire.pc);
            check_field("retire.insn", word, retire.insn);
            check_field("retire.illegal", exp_illegal, retire.illegal);
            check_field("retire.rd_we", exp_rd_we, retire.rd_we);
            check_field("retire.mem_we", exp_mem_we, retire.mem_we);
            if (exp_rd_we) begin
                check_field("retire.rd", word[11:7], retire.rd);
                check_field("retire.rd_data", exp_rd_data, retire.rd_data);
                if (word[11:7] != 5'd0)
                    model_regs[word[11:7]] = exp_rd_data;
            end
            if (exp_mem_we) begin
                check_field("retire.mem_addr", exp_mem_addr, retire.mem_addr);
                check_field("retire.mem_wdata", exp_mem_wdata, retire.mem_wdata);
                model_dmem[exp_mem_addr[`DMEM_AW+1:2]] = exp_mem_wdata;
            end
            exp_pc = exp_pc + 32'd4;
            retired++;
        end
    end

    initial begin
        void'($urandom(32806));
        RST            = 1'b1;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        running        = 1'b0;
        retired        = 0;
        check_count    = 0;
        mismatch_count = 0;
        exp_pc         = `RESET_PC;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            model_dmem[i] = '0;
        end
        build_program();
        repeat (RST_CYCLES) @(posedge CLK);
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge CLK);
            RST       = 1'b0;
            load_en   = 1'b1;
            load_addr = i[`IMEM_AW-1:0];
            load_data = prog[i];
        end
        @(negedge CLK);
        load_en = 1'b0;
        running = 1'b1;
        wait (retired == PROG_WORDS);
        @(negedge CLK);  // Last writes have landed
        for (int i = 0; i < `DMEM_WORDS; i++)
            check_field($sformatf("data_mem[%0d]", i), model_dmem[i],
                        single_cpu_inst.data_mem_inst.mem[i]);
        for (int i = 0; i < `REG_COUNT; i++)
            check_field($sformatf("x%0d", i), model_regs[i],
                        single_cpu_inst.reg_file_inst.regs[i]);
        $display("Checks run: %0d, mismatches: %0d", check_count, mismatch_count);
        if (mismatch_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d of %0d instructions retired",
                 WATCHDOG_NS, retired, PROG_WORDS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
inst_mem.sv
reg_file.sv
data_mem.sv
decoder.sv
alu.sv
single_cpu.sv
tb_single_cpu.sv

/* Bender.yml */
package:
  name: single_cpu

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - core_pkg.sv
  - inst_mem.sv
  - reg_file.sv
  - data_mem.sv
  - decoder.sv
  - alu.sv
  - single_cpu.sv
  - target: test
    files:
      - tb_single_cpu.sv
